//--- list.f
rtl/gpio_pkg.sv
rtl/gpio_input_sync.sv
rtl/gpio_int_ctrl.sv
rtl/gpio_lite_subunit.sv
rtl/gpio_lite.sv
tb/gpio_lite_checker.sv
tb/gpio_lite_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module gpio_lite_tb -f list.f \
   && ./obj_dir/Vgpio_lite_tb | tee /dev/stderr | grep -q "All tests passed!" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- tb/gpio_lite_tb.sv
module gpio_lite_tb;

   localparam int n_rw    = 24;  // readback rounds
   localparam int n_out   = 10;  // pin output rounds
   localparam int n_in    = 10;  // input register rounds
   localparam int n_edge  = 16;  // edge interrupt rounds
   localparam int n_lvl   = 12;  // level interrupt rounds
   localparam int n_xfers = 8 + n_rw * 4 + n_out * 3 + n_in * 3 + 4 + n_edge * 4 + 3 + n_lvl * 3;
   localparam int timeout_cycles = n_xfers * 10 + 16;  // plus reset

   logic                                pclk = 1'b0;
   logic                                reset;
   logic                                psel;
   logic                                penable;
   logic                                pwrite;
   logic [gpio_pkg::apb_addr_width-1:0] paddr;
   logic [gpio_pkg::apb_data_width-1:0] pwdata;
   logic [gpio_pkg::apb_data_width-1:0] prdata;
   logic [gpio_pkg::gpio_width-1:0]     gpio_pin_in;
   logic [gpio_pkg::gpio_width-1:0]     tri_state_enable;
   logic [gpio_pkg::gpio_width-1:0]     gpio_pin_out;
   logic [gpio_pkg::gpio_width-1:0]     n_gpio_pin_oe;
   logic                                gpio_int;

   // shadow registers of the model
   logic [gpio_pkg::gpio_width-1:0] dir_m  = '0;
   logic [gpio_pkg::gpio_width-1:0] out_m  = '0;
   logic [gpio_pkg::gpio_width-1:0] en_m   = '0;
   logic [gpio_pkg::gpio_width-1:0] type_m = '0;
   logic [gpio_pkg::gpio_width-1:0] pol_m  = '0;
   logic [gpio_pkg::gpio_width-1:0] stat_m = '0;
   logic [gpio_pkg::gpio_width-1:0] pins_m = '0;  // settled pin values
   logic [gpio_pkg::gpio_width-1:0] tse_m  = '0;
   int                              errors = 0;
   int                              checks = 0;

   always #20 pclk = ~pclk;

   gpio_lite UUT (
      .pclk (pclk), .reset (reset), .psel (psel), .penable (penable), .pwrite (pwrite),
      .paddr (paddr), .pwdata (pwdata), .prdata (prdata), .gpio_pin_in (gpio_pin_in),
      .tri_state_enable (tri_state_enable), .gpio_pin_out (gpio_pin_out),
      .n_gpio_pin_oe (n_gpio_pin_oe), .gpio_int (gpio_int)
   );

   // -------------------------------------------------------------------
   // reference model
   // -------------------------------------------------------------------

   // level bits whose pin sits at the polarity value
   // pol 1 wants the pin high, pol 0 wants it low
   function automatic logic [15:0] level_events(input logic [15:0] pins);
      return en_m & ~type_m & ((pol_m & pins) | (~pol_m & ~pins));
   endfunction

   function automatic logic [15:0] edge_events(input logic [15:0] prev, input logic [15:0] now);
      logic [15:0] went_high;
      logic [15:0] went_low;
      went_high = ~prev & now;
      went_low  = prev & ~now;
      return en_m & type_m & ((pol_m & went_high) | (~pol_m & went_low));
   endfunction

   function automatic logic [15:0] expected_read(input logic [5:0] addr);
      logic [15:0] val;
      case (gpio_pkg::gpio_reg_e'(addr))
         gpio_pkg::reg_dir        : val = dir_m;
         gpio_pkg::reg_out        : val = out_m;
         gpio_pkg::reg_in         : val = pins_m;
         gpio_pkg::reg_int_en     : val = en_m;
         gpio_pkg::reg_int_type   : val = type_m;
         gpio_pkg::reg_int_pol    : val = pol_m;
         gpio_pkg::reg_int_status : val = stat_m;
         default                  : val = '0;  // holes in the map
      endcase
      return val;
   endfunction

   task automatic model_write(input logic [5:0] addr, input logic [15:0] data);
      case (gpio_pkg::gpio_reg_e'(addr))
         gpio_pkg::reg_dir        : dir_m  = data;
         gpio_pkg::reg_out        : out_m  = data;
         gpio_pkg::reg_int_en     : en_m   = data;
         gpio_pkg::reg_int_type   : type_m = data;
         gpio_pkg::reg_int_pol    : pol_m  = data;
         gpio_pkg::reg_int_status : stat_m = stat_m & ~data;
         default                  : ;
      endcase
      stat_m = stat_m | level_events(pins_m);  // held levels set right back
   endtask

   // -------------------------------------------------------------------
   // bus and pin tasks
   // -------------------------------------------------------------------

   task automatic write_reg(input logic [5:0] addr, input logic [15:0] data);
      @(posedge pclk);
      psel    <= 1'b1;
      pwrite  <= 1'b1;
      penable <= 1'b0;
      paddr   <= addr;
      pwdata  <= {16'($urandom), data};  // junk in the upper half
      @(posedge pclk);
      penable <= 1'b1;
      @(posedge pclk);                   // write lands here
      psel    <= 1'b0;
      penable <= 1'b0;
      model_write(addr, data);
   endtask

   task automatic read_reg(input logic [5:0] addr, output logic [31:0] data);
      @(posedge pclk);
      psel    <= 1'b1;
      pwrite  <= 1'b0;
      penable <= 1'b0;
      paddr   <= addr;
      @(posedge pclk);
      penable <= 1'b1;  // rdata captured on this edge
      @(negedge pclk);
      data = prdata;
      @(posedge pclk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   // new pins then hold until sync and status have settled
   task automatic set_pins(input logic [15:0] pins);
      @(posedge pclk);
      gpio_pin_in <= pins;
      stat_m = stat_m | edge_events(pins_m, pins) | level_events(pins);
      pins_m = pins;
      repeat (4) @(posedge pclk);
   endtask

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   // -------------------------------------------------------------------
   // test sequence
   // -------------------------------------------------------------------

   initial
   begin
      logic [5:0]  addr;
      logic [15:0] data;
      logic [31:0] rd;
      int          k;
      void'($urandom(74));
      reset            <= 1'b1;
      psel             <= 1'b0;
      penable          <= 1'b0;
      pwrite           <= 1'b0;
      paddr            <= '0;
      pwdata           <= '0;
      gpio_pin_in      <= '0;
      tri_state_enable <= '0;
      repeat (16) @(posedge pclk);
      reset <= 1'b0;

      for (int a = 0; a < 8; a++)  // whole map plus first hole
      begin
         read_reg(6'(a * 4), rd);
         check("reset_read", {16'h0, expected_read(6'(a * 4))}, rd);
      end
      @(negedge pclk);
      check("reset_oe_n", 32'hFFFF, 32'(n_gpio_pin_oe));
      check("reset_int", 32'h0, 32'(gpio_int));

      for (int i = 0; i < n_rw; i++)
      begin
         k    = int'($urandom % 5);
         addr = 6'(k < 2 ? k * 4 : (k + 1) * 4);  // skip reg_in
         data = 16'($urandom);
         write_reg(addr, data);
         read_reg(addr, rd);
         check("readback", {16'h0, expected_read(addr)}, rd);
         addr = 6'h1C + 6'($urandom % 36);
         read_reg(addr, rd);
         check("unmapped", 32'h0, rd);
         read_reg(gpio_pkg::reg_int_status, rd);
         check("status_cfg", {16'h0, stat_m}, rd);
      end

      for (int i = 0; i < n_out; i++)
      begin
         write_reg(gpio_pkg::reg_dir, 16'($urandom));
         write_reg(gpio_pkg::reg_out, 16'($urandom));
         tse_m = 16'($urandom);
         tri_state_enable <= tse_m;
         repeat (2) @(posedge pclk);  // oe is registered
         @(negedge pclk);
         check("pin_out", 32'(out_m), 32'(gpio_pin_out));
         check("pin_oe_n", {16'h0, ~dir_m | tse_m}, 32'(n_gpio_pin_oe));
      end

      for (int i = 0; i < n_in; i++)
      begin
         set_pins(16'($urandom));
         read_reg(gpio_pkg::reg_in, rd);
         check("reg_in", {16'h0, pins_m}, rd);
         read_reg(gpio_pkg::reg_int_status, rd);
         check("status_in", {16'h0, stat_m}, rd);
      end

      // edge mode on every pin
      write_reg(gpio_pkg::reg_int_type, 16'hFFFF);
      write_reg(gpio_pkg::reg_int_en, 16'($urandom));
      write_reg(gpio_pkg::reg_int_pol, 16'($urandom));
      write_reg(gpio_pkg::reg_int_status, 16'hFFFF);
      for (int i = 0; i < n_edge; i++)
      begin
         set_pins(16'($urandom));
         read_reg(gpio_pkg::reg_int_status, rd);
         check("edge_status", {16'h0, stat_m}, rd);
         @(negedge pclk);
         check("edge_int", 32'(|stat_m), 32'(gpio_int));
         write_reg(gpio_pkg::reg_int_status, 16'($urandom));  // random w1c mask
         read_reg(gpio_pkg::reg_int_status, rd);
         check("edge_w1c", {16'h0, stat_m}, rd);
      end

      // level mode on every pin
      write_reg(gpio_pkg::reg_int_type, 16'h0000);
      write_reg(gpio_pkg::reg_int_en, 16'($urandom));
      write_reg(gpio_pkg::reg_int_pol, 16'($urandom));
      for (int i = 0; i < n_lvl; i++)
      begin
         set_pins(16'($urandom));
         write_reg(gpio_pkg::reg_int_status, 16'hFFFF);
         read_reg(gpio_pkg::reg_int_status, rd);
         check("level_status", {16'h0, stat_m}, rd);
         @(negedge pclk);
         check("level_int", 32'(|stat_m), 32'(gpio_int));
      end

      errors += UUT.i_gpio_lite_subunit.i_gpio_lite_checker.assert_errors;
      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

   // watchdog sized from the transfer count
   initial
   begin
      #(timeout_cycles * 40);
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("Test failures found");
      $finish;
   end

endmodule

//--- tb/gpio_lite_checker.sv
module gpio_lite_checker (
   input logic                            pclk,
   input logic                            reset,
   input logic [gpio_pkg::gpio_width-1:0] dir_reg,
   input logic [gpio_pkg::gpio_width-1:0] tri_state_enable,
   input logic [gpio_pkg::gpio_width-1:0] int_en_reg,
   input logic [gpio_pkg::gpio_width-1:0] int_status,
   input logic [gpio_pkg::gpio_width-1:0] pin_oe_n
);

   int assert_errors = 0;  // failed assertions so far

   // -------------------------------------------------------------------
   // output enable
   // -------------------------------------------------------------------

   // all pins float while in reset
   oe_in_reset : assert property (@(posedge pclk) reset |=> pin_oe_n == '1)
      else
      begin
         assert_errors++;
         $error("pin_oe_n not all ones during reset");
      end

   // one cycle behind dir and test enable
   oe_rule : assert property (@(posedge pclk) disable iff (reset)
      pin_oe_n == $past(~dir_reg | tri_state_enable))
      else
      begin
         assert_errors++;
         $error("pin_oe_n does not follow dir_reg and tri_state_enable");
      end

   // -------------------------------------------------------------------
   // interrupt status
   // -------------------------------------------------------------------

   no_set_disabled : assert property (@(posedge pclk) disable iff (reset)
      (int_status & ~$past(int_status) & ~$past(int_en_reg)) == '0)
      else
      begin
         assert_errors++;
         $error("status bit set on a disabled pin");
      end

   status_after_reset : assert property (@(posedge pclk) $fell(reset) |-> int_status == '0)
      else
      begin
         assert_errors++;
         $error("int_status not zero after reset");
      end

endmodule

bind gpio_lite_subunit gpio_lite_checker i_gpio_lite_checker (
   .pclk             (pclk),
   .reset            (reset),
   .dir_reg          (dir_reg),
   .tri_state_enable (tri_state_enable),
   .int_en_reg       (int_en_reg),
   .int_status       (int_status),
   .pin_oe_n         (pin_oe_n)
);

//--- rtl/gpio_lite.sv
module gpio_lite (
   input  logic                                 pclk,              // apb clock
   input  logic                                 reset,             // sync, active high
   // apb slave side
   input  logic                                 psel,
   input  logic                                 penable,
   input  logic                                 pwrite,
   input  logic [gpio_pkg::apb_addr_width-1:0]  paddr,
   input  logic [gpio_pkg::apb_data_width-1:0]  pwdata,
   output logic [gpio_pkg::apb_data_width-1:0]  prdata,
   // pin side
   input  logic [gpio_pkg::gpio_width-1:0]      gpio_pin_in,       // async pin inputs
   input  logic [gpio_pkg::gpio_width-1:0]      tri_state_enable,  // test, forces oe off
   output logic [gpio_pkg::gpio_width-1:0]      gpio_pin_out,
   output logic [gpio_pkg::gpio_width-1:0]      n_gpio_pin_oe,     // active low enable
   output logic                                 gpio_int           // any status bit set
);

   logic                            read;        // setup phase of a read
   logic                            write;       // access phase of a write
   logic [gpio_pkg::gpio_width-1:0] rdata;       // registered read data from core
   logic [gpio_pkg::gpio_width-1:0] int_status;  // per pin sticky status

   // -------------------------------------------------------------------
   // apb phase decode
   // -------------------------------------------------------------------

   // read sampled in setup so prdata is ready for access
   assign read  = psel & ~pwrite & ~penable;
   assign write = psel & pwrite & penable;   // no wait states

   // upper half of bus always zero
   assign prdata = {{(gpio_pkg::apb_data_width - gpio_pkg::gpio_width){1'b0}}, rdata};

   // single interrupt line to the system
   assign gpio_int = |int_status;

   // -------------------------------------------------------------------
   // core
   // -------------------------------------------------------------------

   gpio_lite_subunit i_gpio_lite_subunit (
      .pclk             (pclk),
      .reset            (reset),
      .read             (read),
      .write            (write),
      .addr             (paddr),
      .wdata            (pwdata[gpio_pkg::gpio_width-1:0]),  // low half only
      .pin_in           (gpio_pin_in),
      .tri_state_enable (tri_state_enable),
      .rdata            (rdata),
      .int_status       (int_status),
      .pin_out          (gpio_pin_out),
      .pin_oe_n         (n_gpio_pin_oe)
   );

endmodule

//--- rtl/gpio_lite_subunit.sv
module gpio_lite_subunit (
   input  logic                                 pclk,
   input  logic                                 reset,
   input  logic                                 read,              // setup phase strobe
   input  logic                                 write,             // access phase strobe
   input  logic [gpio_pkg::apb_addr_width-1:0]  addr,
   input  logic [gpio_pkg::gpio_width-1:0]      wdata,
   input  logic [gpio_pkg::gpio_width-1:0]      pin_in,            // raw pins
   input  logic [gpio_pkg::gpio_width-1:0]      tri_state_enable,
   output logic [gpio_pkg::gpio_width-1:0]      rdata,
   output logic [gpio_pkg::gpio_width-1:0]      int_status,
   output logic [gpio_pkg::gpio_width-1:0]      pin_out,
   output logic [gpio_pkg::gpio_width-1:0]      pin_oe_n
);

   gpio_pkg::gpio_reg_e             reg_sel;       // decoded offset
   logic [gpio_pkg::gpio_width-1:0] dir_reg;       // 1 drives the pin
   logic [gpio_pkg::gpio_width-1:0] out_reg;
   logic [gpio_pkg::gpio_width-1:0] int_en_reg;
   logic [gpio_pkg::gpio_width-1:0] int_type_reg;
   logic [gpio_pkg::gpio_width-1:0] int_pol_reg;
   logic [gpio_pkg::gpio_width-1:0] pin_sync;      // pins after two flops
   logic [gpio_pkg::gpio_width-1:0] pin_prev;      // pin_sync one cycle back
   logic [gpio_pkg::gpio_width-1:0] status_clear;  // w1c mask this cycle
   logic [gpio_pkg::gpio_width-1:0] rd_mux;

   assign reg_sel = gpio_pkg::gpio_reg_e'(addr);

   // -------------------------------------------------------------------
   // register writes
   // -------------------------------------------------------------------

   always_ff @(posedge pclk)
   begin
      if (reset)
      begin
         dir_reg      <= gpio_pkg::gpio_rst_val;
         out_reg      <= gpio_pkg::gpio_rst_val;
         int_en_reg   <= gpio_pkg::gpio_rst_val;
         int_type_reg <= gpio_pkg::gpio_rst_val;
         int_pol_reg  <= gpio_pkg::gpio_rst_val;
      end
      else if (write)
      begin
         case (reg_sel)
            gpio_pkg::reg_dir      : dir_reg      <= wdata;
            gpio_pkg::reg_out      : out_reg      <= wdata;
            gpio_pkg::reg_int_en   : int_en_reg   <= wdata;
            gpio_pkg::reg_int_type : int_type_reg <= wdata;
            gpio_pkg::reg_int_pol  : int_pol_reg  <= wdata;
            default                : ;  // status handled in int ctrl, in is ro
         endcase
      end
   end

   // only a write to the status offset clears anything
   assign status_clear = (write && (reg_sel == gpio_pkg::reg_int_status)) ?
                         wdata : '0;

   // -------------------------------------------------------------------
   // read path
   // -------------------------------------------------------------------

   always_comb
   begin
      case (reg_sel)
         gpio_pkg::reg_dir        : rd_mux = dir_reg;
         gpio_pkg::reg_out        : rd_mux = out_reg;
         gpio_pkg::reg_in         : rd_mux = pin_sync;
         gpio_pkg::reg_int_en     : rd_mux = int_en_reg;
         gpio_pkg::reg_int_type   : rd_mux = int_type_reg;
         gpio_pkg::reg_int_pol    : rd_mux = int_pol_reg;
         gpio_pkg::reg_int_status : rd_mux = int_status;
         default                  : rd_mux = '0;  // unmapped reads zero
      endcase
   end

   // captured in setup, held through access
   always_ff @(posedge pclk)
   begin
      if (reset)
         rdata <= gpio_pkg::gpio_rst_val;
      else if (read)
         rdata <= rd_mux;
   end

   // -------------------------------------------------------------------
   // pin drive
   // -------------------------------------------------------------------

   // registered, one cycle behind the register write
   always_ff @(posedge pclk)
   begin
      if (reset)
      begin
         pin_out  <= gpio_pkg::gpio_rst_val;
         pin_oe_n <= ~gpio_pkg::gpio_rst_val;  // all inputs
      end
      else
      begin
         pin_out  <= out_reg;
         pin_oe_n <= ~dir_reg | tri_state_enable;  // test mode wins
      end
   end

   gpio_input_sync i_gpio_input_sync (
      .pclk     (pclk),
      .reset    (reset),
      .pin_in   (pin_in),
      .pin_sync (pin_sync),
      .pin_prev (pin_prev)
   );

   gpio_int_ctrl i_gpio_int_ctrl (
      .pclk         (pclk),
      .reset        (reset),
      .pin_sync     (pin_sync),
      .pin_prev     (pin_prev),
      .int_en       (int_en_reg),
      .int_type     (int_type_reg),
      .int_pol      (int_pol_reg),
      .status_clear (status_clear),
      .int_status   (int_status)
   );

endmodule

//--- rtl/gpio_int_ctrl.sv
module gpio_int_ctrl (
   input  logic                            pclk,
   input  logic                            reset,
   input  logic [gpio_pkg::gpio_width-1:0] pin_sync,      // current synced level
   input  logic [gpio_pkg::gpio_width-1:0] pin_prev,      // level one cycle back
   input  logic [gpio_pkg::gpio_width-1:0] int_en,
   input  logic [gpio_pkg::gpio_width-1:0] int_type,      // 1 edge, 0 level
   input  logic [gpio_pkg::gpio_width-1:0] int_pol,       // 1 rise/high
   input  logic [gpio_pkg::gpio_width-1:0] status_clear,  // w1c mask
   output logic [gpio_pkg::gpio_width-1:0] int_status
);

   logic [gpio_pkg::gpio_width-1:0] rise;       // 0 -> 1 seen this cycle
   logic [gpio_pkg::gpio_width-1:0] fall;       // 1 -> 0 seen this cycle
   logic [gpio_pkg::gpio_width-1:0] edge_evt;
   logic [gpio_pkg::gpio_width-1:0] level_evt;
   logic [gpio_pkg::gpio_width-1:0] int_set;    // qualified events

   // -------------------------------------------------------------------
   // event detect
   // -------------------------------------------------------------------

   assign rise = pin_sync & ~pin_prev;
   assign fall = ~pin_sync & pin_prev;

   // polarity picks which edge counts
   assign edge_evt = (int_pol & rise) | (~int_pol & fall);

   // level mode, active while pin matches polarity
   assign level_evt = ~(pin_sync ^ int_pol);

   // type select then enable gate
   // disabled pins never set status
   assign int_set = int_en & ((int_type & edge_evt) | (~int_type & level_evt));

   // -------------------------------------------------------------------
   // sticky status
   // -------------------------------------------------------------------

   // clear first, then or in new events
   // so a set in the same cycle as its clear wins
   // level events keep re-setting while the pin stays matched
   always_ff @(posedge pclk)
   begin
      if (reset)
         int_status <= gpio_pkg::gpio_rst_val;
      else
         int_status <= (int_status & ~status_clear) | int_set;
   end

endmodule

//--- rtl/gpio_input_sync.sv
module gpio_input_sync (
   input  logic                            pclk,
   input  logic                            reset,
   input  logic [gpio_pkg::gpio_width-1:0] pin_in,    // async from pads
   output logic [gpio_pkg::gpio_width-1:0] pin_sync,  // safe to use
   output logic [gpio_pkg::gpio_width-1:0] pin_prev   // for edge detect
);

   logic [gpio_pkg::gpio_width-1:0] pin_meta;  // first stage, may go metastable

   // -------------------------------------------------------------------
   // two flop synchronizer plus history stage
   // -------------------------------------------------------------------

   // pin change shows on pin_sync after two edges
   // pin_prev trails by one more so sync != prev marks an edge
   always_ff @(posedge pclk)
   begin
      if (reset)
      begin
         pin_meta <= gpio_pkg::gpio_rst_val;
         pin_sync <= gpio_pkg::gpio_rst_val;
         pin_prev <= gpio_pkg::gpio_rst_val;
      end
      else
      begin
         pin_meta <= pin_in;
         pin_sync <= pin_meta;  // settled
         pin_prev <= pin_sync;
      end
   end

endmodule

//--- rtl/gpio_pkg.sv
package gpio_pkg;

   // -------------------------------------------------------------------
   // widths
   // -------------------------------------------------------------------

   localparam int gpio_width     = 16;  // io pins on this block
   localparam int apb_addr_width = 6;   // paddr bits, byte offsets
   localparam int apb_data_width = 32;  // full apb data bus

   // -------------------------------------------------------------------
   // register map
   // -------------------------------------------------------------------

   // byte offsets seen on paddr
   // anything not listed reads zero, writes dropped
   typedef enum logic [apb_addr_width-1:0] {
      reg_dir        = 6'h00,  // direction, 1 means output
      reg_out        = 6'h04,  // output data to pins
      reg_in         = 6'h08,  // synced pin values, read only
      reg_int_en     = 6'h0C,  // per pin interrupt enable
      reg_int_type   = 6'h10,  // 1 edge, 0 level
      reg_int_pol    = 6'h14,  // 1 rising or high, 0 falling or low
      reg_int_status = 6'h18   // sticky status, write 1 to clear
   } gpio_reg_e;

   // -------------------------------------------------------------------
   // reset values
   // -------------------------------------------------------------------

   // every register comes up cleared
   // so all pins start as inputs with interrupts off
   localparam logic [gpio_width-1:0] gpio_rst_val = '0;

endpackage
